// File: cnn_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_classifier #(
    parameter int INPUT_LEN    = 16,
    parameter int CLASSES      = 4,
    parameter int CLKS_PER_BIT = 8
) (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    input  logic start,
    output logic tx,
    output logic finished
);
    import cnn_pkg::*;

    byte_t     rx_data;
    logic      rx_rdy;
    byte_t     tx_data;
    logic      tx_en;
    logic      tx_busy;
    logic      xfer_go;
    xfer_op_e  xfer_op;
    file_idx_t xfer_file;
    logic      xfer_done;
    logic      mem_we;
    addr_t     mem_waddr;
    byte_t     mem_wdata;
    addr_t     mem_raddr;
    byte_t     mem_rdata;

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_rx (
        .clk    (clk),
        .reset  (reset),
        .rx     (rx),
        .rx_data(rx_data),
        .rx_rdy (rx_rdy)
    );

    file_transfer #(
        .INPUT_LEN(INPUT_LEN),
        .CLASSES  (CLASSES)
    ) u_xfer (
        .clk      (clk),
        .reset    (reset),
        .xfer_go  (xfer_go),
        .xfer_op  (xfer_op),
        .xfer_file(xfer_file),
        .rx_data  (rx_data),
        .rx_rdy   (rx_rdy),
        .tx_busy  (tx_busy),
        .mem_rdata(mem_rdata),
        .xfer_done(xfer_done),
        .tx_data  (tx_data),
        .tx_en    (tx_en),
        .mem_we   (mem_we),
        .mem_waddr(mem_waddr),
        .mem_wdata(mem_wdata),
        .mem_raddr(mem_raddr)
    );

    dense_layer #(
        .INPUT_LEN(INPUT_LEN),
        .CLASSES  (CLASSES)
    ) u_layer (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .xfer_done(xfer_done),
        .mem_we   (mem_we),
        .mem_waddr(mem_waddr),
        .mem_wdata(mem_wdata),
        .mem_raddr(mem_raddr),
        .finished (finished),
        .xfer_go  (xfer_go),
        .xfer_op  (xfer_op),
        .xfer_file(xfer_file),
        .mem_rdata(mem_rdata)
    );

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_tx (
        .clk    (clk),
        .reset  (reset),
        .tx_data(tx_data),
        .tx_en  (tx_en),
        .tx     (tx),
        .tx_busy(tx_busy)
    );

endmodule

`default_nettype wire

// File: cnn_classifier_sva.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_classifier_sva (
    input logic clk,
    input logic reset,
    input logic tx,
    input logic start,
    input logic finished
);

    // Line idles high through reset
    tx_high_in_reset: assert property (
        @(posedge clk) reset |=> tx
    ) else $error("tx low while reset was asserted");

    finished_low_in_reset: assert property (
        @(posedge clk) reset |=> !finished
    ) else $error("finished high while reset was asserted");

    finished_until_start: assert property (
        @(posedge clk) disable iff (reset)
        finished && !start |=> finished
    ) else $error("finished dropped without a start");

    // No new frame once the answer is out
    tx_quiet_when_finished: assert property (
        @(posedge clk) disable iff (reset)
        finished && tx |=> tx
    ) else $error("tx fell while finished was high");

endmodule

`default_nettype wire

// File: cnn_pkg.sv
`default_nettype none

package cnn_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;
    typedef logic [15:0] file_idx_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } xfer_op_e;

    // Request headers, 'R' and 'W'
    localparam byte_t HDR_READ  = 8'h52;
    localparam byte_t HDR_WRITE = 8'h57;

    // Host file numbers of the classification layer
    localparam file_idx_t FILE_INPUT  = 16'd2402;
    localparam file_idx_t FILE_MATRIX = 16'd2406;
    localparam file_idx_t FILE_BIAS   = 16'd2446;
    localparam file_idx_t FILE_ANSWER = 16'd2447;

    typedef enum logic [2:0] {
        FT_IDLE,
        FT_SEND_HEAD,
        FT_SEND_INDEX,
        FT_READ_BYTE,
        FT_WRITE_BYTE,
        FT_WAIT_TX,
        FT_DONE
    } ft_state_e;

    typedef enum logic [2:0] {
        L_IDLE,
        L_LOAD_INPUT,
        L_LOAD_MATRIX,
        L_LOAD_BIAS,
        L_COMPUTE,
        L_STORE_ANSWER,
        L_FIN
    } layer_state_e;

endpackage

`default_nettype wire

// File: dense_layer.sv
`timescale 1ns/1ps
`default_nettype none

module dense_layer #(
    parameter int INPUT_LEN = 16,
    parameter int CLASSES   = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic               xfer_done,
    input  logic               mem_we,
    input  cnn_pkg::addr_t     mem_waddr,
    input  cnn_pkg::byte_t     mem_wdata,
    input  cnn_pkg::addr_t     mem_raddr,
    output logic               finished,
    output logic               xfer_go,
    output cnn_pkg::xfer_op_e  xfer_op,
    output cnn_pkg::file_idx_t xfer_file,
    output cnn_pkg::byte_t     mem_rdata
);
    import cnn_pkg::*;

    localparam int    MEM_SIZE  = INPUT_LEN + CLASSES * INPUT_LEN + 2 * CLASSES;
    localparam int    AW        = $clog2(MEM_SIZE);
    localparam int    XW        = $clog2(INPUT_LEN);
    localparam int    SW        = $clog2(INPUT_LEN + 2);
    localparam int    CW        = $clog2(CLASSES + 1);
    localparam addr_t MAT_BASE  = addr_t'(INPUT_LEN);
    localparam addr_t BIAS_BASE = addr_t'(INPUT_LEN + CLASSES * INPUT_LEN);
    localparam addr_t ANS_BASE  = BIAS_BASE + addr_t'(CLASSES);
    localparam logic [SW-1:0] LAST_STEP = SW'(INPUT_LEN + 1);

    layer_state_e  state;
    logic [CW-1:0] cls;
    logic [SW-1:0] step;     // 0 bias fetch, 1 bias load, then one product each
    addr_t         w_addr;   // Walks the matrix row-major
    byte_t         acc;

    byte_t         mem [MEM_SIZE];
    byte_t         x_vec [INPUT_LEN];   // Input copy, the second MAC operand
    byte_t         dp_rdata;
    addr_t         dp_raddr;
    logic [XW-1:0] x_idx;
    byte_t         prod;
    byte_t         mac_sum;
    logic          calc_we;
    logic          wr_en;
    addr_t         wr_addr;
    byte_t         wr_data;

    assign dp_raddr = (step == '0) ? BIAS_BASE + addr_t'(cls) : w_addr;
    assign x_idx    = XW'(step - SW'(2));
    assign prod     = x_vec[x_idx] * dp_rdata;   // Low 8 bits only
    assign mac_sum  = acc + prod;
    assign calc_we  = (state == L_COMPUTE) && (step == LAST_STEP);

    // Transfers and answer stores never overlap in time
    assign wr_en   = mem_we || calc_we;
    assign wr_addr = mem_we ? mem_waddr : ANS_BASE + addr_t'(cls);
    assign wr_data = mem_we ? mem_wdata : mac_sum;

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr[AW-1:0]] <= wr_data;
        if (mem_we && mem_waddr < MAT_BASE)
            x_vec[mem_waddr[XW-1:0]] <= mem_wdata;
        mem_rdata <= mem[mem_raddr[AW-1:0]];
        dp_rdata  <= mem[dp_raddr[AW-1:0]];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= L_IDLE;
            finished  <= 1'b0;
            xfer_go   <= 1'b0;
            xfer_op   <= OP_READ;
            xfer_file <= FILE_INPUT;
            cls       <= '0;
            step      <= '0;
            w_addr    <= '0;
            acc       <= '0;
        end else begin
            xfer_go <= 1'b0;
            case (state)
                L_IDLE, L_FIN: begin
                    if (start) begin
                        finished  <= 1'b0;
                        xfer_go   <= 1'b1;
                        xfer_op   <= OP_READ;
                        xfer_file <= FILE_INPUT;
                        state     <= L_LOAD_INPUT;
                    end
                end
                L_LOAD_INPUT: begin
                    if (xfer_done) begin
                        xfer_go   <= 1'b1;
                        xfer_file <= FILE_MATRIX;
                        state     <= L_LOAD_MATRIX;
                    end
                end
                L_LOAD_MATRIX: begin
                    if (xfer_done) begin
                        xfer_go   <= 1'b1;
                        xfer_file <= FILE_BIAS;
                        state     <= L_LOAD_BIAS;
                    end
                end
                L_LOAD_BIAS: begin
                    if (xfer_done) begin
                        cls    <= '0;
                        step   <= '0;
                        w_addr <= MAT_BASE;
                        state  <= L_COMPUTE;
                    end
                end
                L_COMPUTE: begin
                    if (step == SW'(1))
                        acc <= dp_rdata;   // Bias seeds the sum
                    else if (step != '0)
                        acc <= mac_sum;
                    if (step != '0 && step != LAST_STEP)
                        w_addr <= w_addr + 1'b1;
                    if (step == LAST_STEP) begin
                        step <= '0;
                        cls  <= cls + 1'b1;
                        if (cls == CW'(CLASSES - 1)) begin
                            xfer_go   <= 1'b1;
                            xfer_op   <= OP_WRITE;
                            xfer_file <= FILE_ANSWER;
                            state     <= L_STORE_ANSWER;
                        end
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                L_STORE_ANSWER: begin
                    if (xfer_done) begin
                        finished <= 1'b1;
                        state    <= L_FIN;
                    end
                end
                default: state <= L_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: file_transfer.sv
`timescale 1ns/1ps
`default_nettype none

module file_transfer #(
    parameter int INPUT_LEN = 16,
    parameter int CLASSES   = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               xfer_go,
    input  cnn_pkg::xfer_op_e  xfer_op,
    input  cnn_pkg::file_idx_t xfer_file,
    input  cnn_pkg::byte_t     rx_data,
    input  logic               rx_rdy,
    input  logic               tx_busy,
    input  cnn_pkg::byte_t     mem_rdata,
    output logic               xfer_done,
    output cnn_pkg::byte_t     tx_data,
    output logic               tx_en,
    output logic               mem_we,
    output cnn_pkg::addr_t     mem_waddr,
    output cnn_pkg::byte_t     mem_wdata,
    output cnn_pkg::addr_t     mem_raddr
);
    import cnn_pkg::*;

    localparam addr_t MAT_BASE  = addr_t'(INPUT_LEN);
    localparam addr_t BIAS_BASE = addr_t'(INPUT_LEN + CLASSES * INPUT_LEN);
    localparam addr_t ANS_BASE  = BIAS_BASE + addr_t'(CLASSES);

    ft_state_e state;
    ft_state_e ret_state;   // Resumed after FT_WAIT_TX
    xfer_op_e  op;
    file_idx_t file;
    logic      idx_high;
    addr_t     pos;
    addr_t     reg_start;
    addr_t     reg_end;     // Last address of the region

    always_comb begin
        case (file)
            FILE_INPUT: begin
                reg_start = '0;
                reg_end   = MAT_BASE - 1'b1;
            end
            FILE_MATRIX: begin
                reg_start = MAT_BASE;
                reg_end   = BIAS_BASE - 1'b1;
            end
            FILE_BIAS: begin
                reg_start = BIAS_BASE;
                reg_end   = ANS_BASE - 1'b1;
            end
            FILE_ANSWER: begin
                reg_start = ANS_BASE;
                reg_end   = ANS_BASE + addr_t'(CLASSES - 1);
            end
            default: begin   // Unknown file moves a single byte
                reg_start = '0;
                reg_end   = '0;
            end
        endcase
    end

    assign mem_raddr = pos;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= FT_IDLE;
            ret_state <= FT_IDLE;
            op        <= OP_READ;
            file      <= '0;
            idx_high  <= 1'b0;
            pos       <= '0;
            xfer_done <= 1'b0;
            tx_data   <= '0;
            tx_en     <= 1'b0;
            mem_we    <= 1'b0;
            mem_waddr <= '0;
            mem_wdata <= '0;
        end else begin
            xfer_done <= 1'b0;
            tx_en     <= 1'b0;
            mem_we    <= 1'b0;
            case (state)
                FT_IDLE: begin
                    if (xfer_go) begin
                        op    <= xfer_op;
                        file  <= xfer_file;
                        state <= FT_SEND_HEAD;
                    end
                end
                FT_SEND_HEAD: begin
                    if (!tx_busy) begin
                        tx_data   <= (op == OP_READ) ? HDR_READ : HDR_WRITE;
                        tx_en     <= 1'b1;
                        idx_high  <= 1'b1;
                        ret_state <= FT_SEND_INDEX;
                        state     <= FT_WAIT_TX;
                    end
                end
                FT_SEND_INDEX: begin
                    if (!tx_busy) begin
                        tx_en    <= 1'b1;
                        idx_high <= 1'b0;
                        state    <= FT_WAIT_TX;
                        if (idx_high) begin
                            tx_data   <= file[15:8];
                            ret_state <= FT_SEND_INDEX;
                        end else begin
                            tx_data   <= file[7:0];
                            pos       <= reg_start;
                            ret_state <= (op == OP_READ) ? FT_READ_BYTE : FT_WRITE_BYTE;
                        end
                    end
                end
                FT_READ_BYTE: begin
                    if (rx_rdy) begin
                        mem_we    <= 1'b1;
                        mem_waddr <= pos;
                        mem_wdata <= rx_data;
                        pos       <= pos + 1'b1;
                        if (pos == reg_end)
                            state <= FT_DONE;
                    end
                end
                FT_WRITE_BYTE: begin
                    if (!tx_busy) begin
                        tx_data   <= mem_rdata;   // Fetched while the last byte went out
                        tx_en     <= 1'b1;
                        pos       <= pos + 1'b1;
                        ret_state <= (pos == reg_end) ? FT_DONE : FT_WRITE_BYTE;
                        state     <= FT_WAIT_TX;
                    end
                end
                FT_WAIT_TX: begin
                    // Busy rises a cycle after tx_en
                    if (!tx_en && !tx_busy)
                        state <= ret_state;
                end
                FT_DONE: begin
                    xfer_done <= 1'b1;
                    state     <= FT_IDLE;
                end
                default: state <= FT_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: project.f
cnn_pkg.sv
uart_rx.sv
uart_tx.sv
file_transfer.sv
dense_layer.sv
cnn_classifier.sv
cnn_classifier_sva.sv
tb_cnn_classifier.sv

// File: run.sh
#!/bin/sh
# Compile and run the classifier testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cnn_classifier \
    --Mdir obj_dir -o Vtb_cnn_classifier \
    -f project.f
status=$?
if [ $status -ne 0 ]; then
    echo "Compile step failed with status $status"
    exit $status
fi

./obj_dir/Vtb_cnn_classifier
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0

// File: tb_cnn_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cnn_classifier;

    localparam int INPUT_LEN    = 16;
    localparam int CLASSES      = 4;
    localparam int CLKS_PER_BIT = 8;
    localparam int CLK_PERIOD   = 4;
    localparam int BIAS_OFS     = INPUT_LEN + CLASSES * INPUT_LEN;
    localparam int HOST_BYTES   = BIAS_OFS + CLASSES;   // Input, matrix, bias back to back

    localparam logic [7:0]  HDR_R       = 8'h52;
    localparam logic [7:0]  HDR_W       = 8'h57;
    localparam logic [15:0] FILE_INPUT  = 16'd2402;
    localparam logic [15:0] FILE_MATRIX = 16'd2406;
    localparam logic [15:0] FILE_BIAS   = 16'd2446;
    localparam logic [15:0] FILE_ANSWER = 16'd2447;

    // Four requests of three bytes each, then the data bytes
    localparam int BYTES_PER_RUN   = 4 * 3 + HOST_BYTES + CLASSES;
    localparam int RUN_CYCLES      = BYTES_PER_RUN * 10 * CLKS_PER_BIT * 2;
    localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES + 4000;

    logic        clk;
    logic        reset;
    logic        rx;
    logic        start;
    logic        tx;
    logic        finished;

    logic [31:0] lfsr_state;
    logic [7:0]  host_mem [HOST_BYTES];
    logic [7:0]  ans_q [$];
    logic        host_sending;
    int          n_checked;
    int          n_expected;
    int          cmp_cls;
    logic [7:0]  cmp_got;

    cnn_classifier #(
        .INPUT_LEN   (INPUT_LEN),
        .CLASSES     (CLASSES),
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) dut (
        .clk     (clk),
        .reset   (reset),
        .rx      (rx),
        .start   (start),
        .tx      (tx),
        .finished(finished)
    );

    bind cnn_classifier cnn_classifier_sva u_sva (
        .clk     (clk),
        .reset   (reset),
        .tx      (tx),
        .start   (start),
        .finished(finished)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("Test failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected 0x%0h actual 0x%0h", name, expected, actual);
            abort_run("value mismatch");
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int j = 0; j < n; j++) begin
            v = {v[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // Bias plus dot product of the input with row k, wrapping at 8 bits
    function automatic logic [7:0] ref_answer(input int k);
        logic [7:0] sum;
        sum = host_mem[BIAS_OFS + k];
        for (int i = 0; i < INPUT_LEN; i++)
            sum = sum + host_mem[i] * host_mem[INPUT_LEN + k * INPUT_LEN + i];
        return sum;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_byte(input logic [7:0] b, input logic last);
        rx = 1'b0;
        wait_cycles(CLKS_PER_BIT);
        for (int i = 0; i < 8; i++) begin
            rx = b[i];   // LSB first
            wait_cycles(CLKS_PER_BIT);
        end
        rx = 1'b1;
        if (last)
            host_sending = 1'b0;   // Region fully on the line
        wait_cycles(CLKS_PER_BIT);
    endtask

    task automatic send_range(input int base, input int len);
        logic [7:0] gap;
        @(posedge clk);
        #1;
        host_sending = 1'b1;
        for (int n = 0; n < len; n++) begin
            gap = rand_bits(3);
            wait_cycles(int'(gap) * CLKS_PER_BIT);
            send_byte(host_mem[base + n], n == len - 1);
        end
    endtask

    task automatic receive_byte(output logic [7:0] b);
        @(negedge clk);
        while (tx !== 1'b0)
            @(negedge clk);
        repeat (3) @(negedge clk);
        if (tx !== 1'b0)
            abort_run("start bit on tx did not last to mid-bit");
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            b[i] = tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (tx !== 1'b1)
            abort_run("stop bit on tx was low");
    endtask

    task automatic expect_request(input logic [7:0] hdr, input logic [15:0] file);
        logic [7:0] b;
        receive_byte(b);
        check_value("tx header", hdr, b);
        receive_byte(b);
        check_value("tx index_hi", file[15:8], b);
        receive_byte(b);
        check_value("tx index_lo", file[7:0], b);
    endtask

    task automatic run_inference();
        logic [7:0] b;
        for (int k = 0; k < HOST_BYTES; k++)
            host_mem[k] = rand_bits(8);
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        @(negedge clk);
        check_value("finished", 1'b0, finished);   // Cleared by start

        expect_request(HDR_R, FILE_INPUT);
        send_range(0, INPUT_LEN);
        expect_request(HDR_R, FILE_MATRIX);
        send_range(INPUT_LEN, CLASSES * INPUT_LEN);
        expect_request(HDR_R, FILE_BIAS);
        send_range(BIAS_OFS, CLASSES);

        expect_request(HDR_W, FILE_ANSWER);
        for (int k = 0; k < CLASSES; k++) begin
            receive_byte(b);
            ans_q.push_back(b);
        end
        n_expected = n_expected + CLASSES;
        while (finished !== 1'b1) begin
            @(negedge clk);
            if (tx !== 1'b1)
                abort_run("DUT sent more answer bytes than there are classes");
        end
        while (n_checked < n_expected)
            @(negedge clk);
    endtask

    // Answer bytes arrive in class order
    always @(negedge clk) begin
        if (ans_q.size() > 0) begin
            cmp_got = ans_q.pop_front();
            cmp_cls = n_checked % CLASSES;
            check_value($sformatf("tx answer[%0d]", cmp_cls), ref_answer(cmp_cls), cmp_got);
            n_checked = n_checked + 1;
        end
    end

    // The DUT stays quiet while the host sends a region
    always @(negedge clk) begin
        if (host_sending && tx !== 1'b1)
            abort_run("DUT sent on tx before the host finished sending the region");
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("timeout, the run did not complete in time");
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        rx           = 1'b1;
        start        = 1'b0;
        lfsr_state   = 32'h4232885f;
        host_sending = 1'b0;
        n_checked    = 0;
        n_expected   = 0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        @(negedge clk);
        check_value("tx", 1'b1, tx);
        check_value("finished", 1'b0, finished);
        repeat (100) begin
            @(negedge clk);
            check_value("tx", 1'b1, tx);   // Idle line without start
        end

        run_inference();
        run_inference();   // Fresh data and gaps

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           rx,
    output cnn_pkg::byte_t rx_data,
    output logic           rx_rdy
);
    import cnn_pkg::*;

    localparam int CW = $clog2(CLKS_PER_BIT);

    logic          rx_s1;
    logic          rx_s2;
    logic          rx_s3;     // Previous synced level, for edge detect
    logic          active;
    logic [3:0]    bit_idx;   // 0 start, 1..8 data, 9 stop
    logic [CW-1:0] clk_cnt;
    byte_t         shift;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_s1 <= 1'b1;
            rx_s2 <= 1'b1;
            rx_s3 <= 1'b1;
        end else begin
            rx_s1 <= rx;
            rx_s2 <= rx_s1;
            rx_s3 <= rx_s2;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active  <= 1'b0;
            bit_idx <= '0;
            clk_cnt <= '0;
            shift   <= '0;
            rx_data <= '0;
            rx_rdy  <= 1'b0;
        end else begin
            rx_rdy <= 1'b0;
            if (!active) begin
                if (rx_s3 && !rx_s2) begin
                    active  <= 1'b1;
                    bit_idx <= '0;
                    clk_cnt <= CW'(CLKS_PER_BIT / 2 - 1);   // Half a bit to mid-start
                end
            end else if (clk_cnt != '0) begin
                clk_cnt <= clk_cnt - 1'b1;
            end else begin
                clk_cnt <= CW'(CLKS_PER_BIT - 1);
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 4'd0) begin
                    active <= !rx_s2;   // Start bit gone high means a glitch
                end else if (bit_idx == 4'd9) begin
                    active <= 1'b0;
                    if (rx_s2) begin
                        rx_data <= shift;
                        rx_rdy  <= 1'b1;
                    end
                end else begin
                    shift <= {rx_s2, shift[7:1]};   // LSB first
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic           clk,
    input  logic           reset,
    input  cnn_pkg::byte_t tx_data,
    input  logic           tx_en,
    output logic           tx,
    output logic           tx_busy
);

    localparam int CW = $clog2(CLKS_PER_BIT);

    logic [8:0]    frame;       // Data bits then the stop bit
    logic [3:0]    bits_left;
    logic [CW-1:0] clk_cnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx        <= 1'b1;
            tx_busy   <= 1'b0;
            frame     <= '1;
            bits_left <= '0;
            clk_cnt   <= '0;
        end else if (tx_en && !tx_busy) begin
            tx        <= 1'b0;   // Start bit
            tx_busy   <= 1'b1;
            frame     <= {1'b1, tx_data};
            bits_left <= 4'd9;
            clk_cnt   <= CW'(CLKS_PER_BIT - 1);
        end else if (tx_busy) begin
            if (clk_cnt != '0) begin
                clk_cnt <= clk_cnt - 1'b1;
            end else if (bits_left != '0) begin
                tx        <= frame[0];
                frame     <= {1'b1, frame[8:1]};
                bits_left <= bits_left - 1'b1;
                clk_cnt   <= CW'(CLKS_PER_BIT - 1);
            end else begin
                tx_busy <= 1'b0;   // End of stop bit
            end
        end
    end

endmodule

`default_nettype wire
